/* common/riscv_pkg.sv */
package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_op_t;

    // major opcodes of the supported subset
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t pc_plus4;
        logic  valid;
    } if_id_t;

    typedef struct packed {
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        alu_op_t   alu_op;
        logic      alu_src;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        logic      branch;
        logic      branch_ne;
        word_t     pc;
    } id_ex_t;

    typedef struct packed {
        word_t     result;
        word_t     store_data;
        reg_addr_t rd;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
    } ex_mem_t;

    typedef struct packed {
        word_t     result;
        word_t     load_data;
        reg_addr_t rd;
        logic      mem_to_reg;
        logic      reg_write;
    } mem_wb_t;

    // caches hold big-endian words
    function automatic word_t byte_swap(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

/* fetch/fetch_stage.sv */
module fetch_stage (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              freeze_i,
    input  logic              hazard_stall_i,
    input  logic              branch_taken_i,
    input  riscv_pkg::word_t  branch_target_i,
    input  riscv_pkg::word_t  icache_rdata_i,
    output logic [29:0]       icache_addr_o,
    output riscv_pkg::word_t  pc_o,
    output riscv_pkg::if_id_t if_id_o
);
    import riscv_pkg::*;

    word_t  pc;
    word_t  pc_next;
    word_t  pc_plus4;
    word_t  instr;
    word_t  jal_imm;
    logic   is_jal;
    if_id_t if_id_q;

    assign instr    = byte_swap(icache_rdata_i);
    assign pc_plus4 = pc + 32'd4;
    assign is_jal   = (instr[6:0] == OP_JAL);

    // J-type immediate, imm[20|10:1|11|19:12]
    assign jal_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        if (branch_taken_i) begin
            pc_next = branch_target_i;
        end else if (hazard_stall_i) begin
            pc_next = pc;
        end else if (is_jal) begin
            pc_next = pc + jal_imm;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc <= '0;
        end else if (!freeze_i) begin
            pc <= pc_next;
        end
    end

    // squash on redirect, hold on load-use
    always_ff @(posedge clk) begin
        if (reset_i) begin
            if_id_q.valid <= 1'b0;
        end else if (!freeze_i) begin
            if (branch_taken_i) begin
                if_id_q.valid <= 1'b0;
            end else if (!hazard_stall_i) begin
                if_id_q.instr    <= instr;
                if_id_q.pc       <= pc;
                if_id_q.pc_plus4 <= pc_plus4;
                if_id_q.valid    <= 1'b1;
            end
        end
    end

    assign icache_addr_o = pc[31:2];
    assign pc_o          = pc;
    assign if_id_o       = if_id_q;

endmodule

/* decode/register_file.sv */
module register_file (
    input  logic                 clk,
    input  logic                 reset_i,
    input  riscv_pkg::reg_addr_t rs1_i,
    input  riscv_pkg::reg_addr_t rs2_i,
    input  riscv_pkg::reg_addr_t wb_rd_i,
    input  riscv_pkg::word_t     wb_data_i,
    input  logic                 wb_we_i,
    output riscv_pkg::word_t     rs1_data_o,
    output riscv_pkg::word_t     rs2_data_o
);
    import riscv_pkg::*;

    // x0 is not stored
    word_t regs [1:31];
    logic  wr_en;

    assign wr_en = wb_we_i && (wb_rd_i != '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_rd_i] <= wb_data_i;
        end
    end

    // same-cycle write is visible to the reader
    assign rs1_data_o = (rs1_i == '0) ? '0 :
                        (wr_en && wb_rd_i == rs1_i) ? wb_data_i : regs[rs1_i];
    assign rs2_data_o = (rs2_i == '0) ? '0 :
                        (wr_en && wb_rd_i == rs2_i) ? wb_data_i : regs[rs2_i];

endmodule

/* decode/decode_stage.sv */
module decode_stage (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 freeze_i,
    input  riscv_pkg::if_id_t    if_id_i,
    input  riscv_pkg::reg_addr_t ex_rd_i,
    input  logic                 ex_mem_read_i,
    input  logic                 branch_taken_i,
    input  riscv_pkg::reg_addr_t wb_rd_i,
    input  riscv_pkg::word_t     wb_data_i,
    input  logic                 wb_we_i,
    output riscv_pkg::id_ex_t    id_ex_o,
    output logic                 hazard_stall_o
);
    import riscv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    alu_op_t    alu_fn;
    logic       uses_rs1;
    logic       uses_rs2;
    id_ex_t     dec;
    id_ex_t     id_ex_q;

    assign opcode = if_id_i.instr[6:0];
    assign funct3 = if_id_i.instr[14:12];
    assign rs1    = if_id_i.instr[19:15];
    assign rs2    = if_id_i.instr[24:20];

    assign imm_i = {{20{if_id_i.instr[31]}}, if_id_i.instr[31:20]};
    assign imm_s = {{20{if_id_i.instr[31]}}, if_id_i.instr[31:25], if_id_i.instr[11:7]};
    assign imm_b = {{20{if_id_i.instr[31]}}, if_id_i.instr[7], if_id_i.instr[30:25],
                    if_id_i.instr[11:8], 1'b0};

    assign uses_rs1 = (opcode != OP_JAL);
    assign uses_rs2 = (opcode == OP_REG) || (opcode == OP_STORE) || (opcode == OP_BRANCH);

    register_file u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_i      (rs1),
        .rs2_i      (rs2),
        .wb_rd_i    (wb_rd_i),
        .wb_data_i  (wb_data_i),
        .wb_we_i    (wb_we_i),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    // funct7 bit 30 only selects sub on register ops
    always_comb begin
        case (funct3)
            3'b111:  alu_fn = ALU_AND;
            3'b110:  alu_fn = ALU_OR;
            3'b010:  alu_fn = ALU_SLT;
            default: alu_fn = (opcode == OP_REG && if_id_i.instr[30]) ? ALU_SUB : ALU_ADD;
        endcase
    end

    always_comb begin
        dec           = '0;
        dec.rs1_data  = rs1_data;
        dec.rs2_data  = rs2_data;
        dec.rs1       = uses_rs1 ? rs1 : '0;
        dec.rs2       = uses_rs2 ? rs2 : '0;
        dec.rd        = if_id_i.instr[11:7];
        dec.pc        = if_id_i.pc;
        dec.alu_op    = ALU_ADD;
        dec.branch_ne = funct3[0];
        if (if_id_i.valid) begin
            case (opcode)
                OP_REG: begin
                    dec.reg_write = 1'b1;
                    dec.alu_op    = alu_fn;
                end
                OP_IMM: begin
                    dec.reg_write = 1'b1;
                    dec.alu_src   = 1'b1;
                    dec.alu_op    = alu_fn;
                    dec.imm       = imm_i;
                end
                OP_LOAD: begin
                    dec.reg_write = 1'b1;
                    dec.mem_read  = 1'b1;
                    dec.alu_src   = 1'b1;
                    dec.imm       = imm_i;
                end
                OP_STORE: begin
                    dec.mem_write = 1'b1;
                    dec.alu_src   = 1'b1;
                    dec.imm       = imm_s;
                end
                OP_BRANCH: begin
                    dec.branch = 1'b1;
                    dec.imm    = imm_b;
                end
                OP_JAL: begin
                    // link value pc+4 passes the ALU as pc_plus4 + 0
                    dec.reg_write = 1'b1;
                    dec.alu_src   = 1'b1;
                    dec.rs1_data  = if_id_i.pc_plus4;
                end
                default: ;
            endcase
        end
    end

    assign hazard_stall_o = if_id_i.valid && ex_mem_read_i && (ex_rd_i != '0) &&
                            ((uses_rs1 && rs1 == ex_rd_i) || (uses_rs2 && rs2 == ex_rd_i));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            id_ex_q.reg_write <= 1'b0;
            id_ex_q.mem_read  <= 1'b0;
            id_ex_q.mem_write <= 1'b0;
            id_ex_q.branch    <= 1'b0;
        end else if (!freeze_i) begin
            if (branch_taken_i || hazard_stall_o) begin
                // bubble
                id_ex_q.reg_write <= 1'b0;
                id_ex_q.mem_read  <= 1'b0;
                id_ex_q.mem_write <= 1'b0;
                id_ex_q.branch    <= 1'b0;
            end else begin
                id_ex_q <= dec;
            end
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

/* execute/execute_stage.sv */
module execute_stage (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 freeze_i,
    input  riscv_pkg::id_ex_t    id_ex_i,
    input  riscv_pkg::word_t     mem_result_i,
    input  riscv_pkg::reg_addr_t mem_rd_i,
    input  logic                 mem_reg_write_i,
    input  riscv_pkg::word_t     wb_data_i,
    input  riscv_pkg::reg_addr_t wb_rd_i,
    input  logic                 wb_we_i,
    output riscv_pkg::ex_mem_t   ex_mem_o,
    output logic                 branch_taken_o,
    output riscv_pkg::word_t     branch_target_o,
    output riscv_pkg::reg_addr_t ex_rd_o,
    output logic                 ex_mem_read_o
);
    import riscv_pkg::*;

    word_t   fwd_a;
    word_t   fwd_b;
    word_t   op_b;
    word_t   alu_result;
    logic    operands_eq;
    ex_mem_t ex_mem_q;

    // memory stage is the younger result and wins
    always_comb begin
        if (mem_reg_write_i && mem_rd_i != '0 && mem_rd_i == id_ex_i.rs1) begin
            fwd_a = mem_result_i;
        end else if (wb_we_i && wb_rd_i != '0 && wb_rd_i == id_ex_i.rs1) begin
            fwd_a = wb_data_i;
        end else begin
            fwd_a = id_ex_i.rs1_data;
        end
    end

    always_comb begin
        if (mem_reg_write_i && mem_rd_i != '0 && mem_rd_i == id_ex_i.rs2) begin
            fwd_b = mem_result_i;
        end else if (wb_we_i && wb_rd_i != '0 && wb_rd_i == id_ex_i.rs2) begin
            fwd_b = wb_data_i;
        end else begin
            fwd_b = id_ex_i.rs2_data;
        end
    end

    assign op_b = id_ex_i.alu_src ? id_ex_i.imm : fwd_b;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_SUB: alu_result = fwd_a - op_b;
            ALU_AND: alu_result = fwd_a & op_b;
            ALU_OR:  alu_result = fwd_a | op_b;
            ALU_SLT: alu_result = {31'b0, $signed(fwd_a) < $signed(op_b)};
            default: alu_result = fwd_a + op_b;
        endcase
    end

    // beq / bne on forwarded register values
    assign operands_eq     = (fwd_a == fwd_b);
    assign branch_taken_o  = id_ex_i.branch && (id_ex_i.branch_ne ? !operands_eq : operands_eq);
    assign branch_target_o = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_mem_q.mem_read  <= 1'b0;
            ex_mem_q.mem_write <= 1'b0;
            ex_mem_q.reg_write <= 1'b0;
        end else if (!freeze_i) begin
            ex_mem_q.result     <= alu_result;
            ex_mem_q.store_data <= fwd_b;
            ex_mem_q.rd         <= id_ex_i.rd;
            ex_mem_q.mem_read   <= id_ex_i.mem_read;
            ex_mem_q.mem_write  <= id_ex_i.mem_write;
            ex_mem_q.reg_write  <= id_ex_i.reg_write;
        end
    end

    assign ex_mem_o      = ex_mem_q;
    assign ex_rd_o       = id_ex_i.rd;
    assign ex_mem_read_o = id_ex_i.mem_read;

endmodule

/* src/memory_writeback.sv */
module memory_writeback (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 freeze_i,
    input  riscv_pkg::ex_mem_t   ex_mem_i,
    input  riscv_pkg::word_t     dcache_rdata_i,
    output logic                 dcache_ren_o,
    output logic                 dcache_wen_o,
    output logic [29:0]          dcache_addr_o,
    output riscv_pkg::word_t     dcache_wdata_o,
    output riscv_pkg::word_t     mem_result_o,
    output riscv_pkg::reg_addr_t mem_rd_o,
    output logic                 mem_reg_write_o,
    output riscv_pkg::reg_addr_t wb_rd_o,
    output riscv_pkg::word_t     wb_data_o,
    output logic                 wb_we_o
);
    import riscv_pkg::*;

    mem_wb_t mem_wb_q;

    // enables follow the held ex_mem register through a stall
    assign dcache_ren_o   = ex_mem_i.mem_read;
    assign dcache_wen_o   = ex_mem_i.mem_write;
    assign dcache_addr_o  = ex_mem_i.result[31:2];
    assign dcache_wdata_o = byte_swap(ex_mem_i.store_data);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_wb_q.mem_to_reg <= 1'b0;
            mem_wb_q.reg_write  <= 1'b0;
        end else if (!freeze_i) begin
            mem_wb_q.result     <= ex_mem_i.result;
            mem_wb_q.load_data  <= byte_swap(dcache_rdata_i);
            mem_wb_q.rd         <= ex_mem_i.rd;
            mem_wb_q.mem_to_reg <= ex_mem_i.mem_read;
            mem_wb_q.reg_write  <= ex_mem_i.reg_write;
        end
    end

    assign mem_result_o    = ex_mem_i.result;
    assign mem_rd_o        = ex_mem_i.rd;
    assign mem_reg_write_o = ex_mem_i.reg_write;

    assign wb_rd_o   = mem_wb_q.rd;
    assign wb_we_o   = mem_wb_q.reg_write;
    assign wb_data_o = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.result;

endmodule

/* src/riscv_pipeline.sv */
module riscv_pipeline (
    input  logic             clk,
    input  logic             reset_i,
    // instruction cache
    output logic [29:0]      icache_addr_o,
    input  riscv_pkg::word_t icache_rdata_i,
    input  logic             icache_stall_i,
    // data cache
    output logic             dcache_ren_o,
    output logic             dcache_wen_o,
    output logic [29:0]      dcache_addr_o,
    output riscv_pkg::word_t dcache_wdata_o,
    input  riscv_pkg::word_t dcache_rdata_i,
    input  logic             dcache_stall_i,
    output riscv_pkg::word_t pc_o
);
    import riscv_pkg::*;

    logic      mem_stall;
    logic      hazard_stall;
    logic      branch_taken;
    word_t     branch_target;
    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    reg_addr_t ex_rd;
    logic      ex_mem_read;
    word_t     mem_result;
    reg_addr_t mem_rd;
    logic      mem_reg_write;
    reg_addr_t wb_rd;
    word_t     wb_data;
    logic      wb_we;

    // either cache stalling freezes every stage
    assign mem_stall = icache_stall_i | dcache_stall_i;

    fetch_stage u_fetch (
        .clk             (clk),
        .reset_i         (reset_i),
        .freeze_i        (mem_stall),
        .hazard_stall_i  (hazard_stall),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .icache_rdata_i  (icache_rdata_i),
        .icache_addr_o   (icache_addr_o),
        .pc_o            (pc_o),
        .if_id_o         (if_id)
    );

    decode_stage u_decode (
        .clk            (clk),
        .reset_i        (reset_i),
        .freeze_i       (mem_stall),
        .if_id_i        (if_id),
        .ex_rd_i        (ex_rd),
        .ex_mem_read_i  (ex_mem_read),
        .branch_taken_i (branch_taken),
        .wb_rd_i        (wb_rd),
        .wb_data_i      (wb_data),
        .wb_we_i        (wb_we),
        .id_ex_o        (id_ex),
        .hazard_stall_o (hazard_stall)
    );

    execute_stage u_execute (
        .clk             (clk),
        .reset_i         (reset_i),
        .freeze_i        (mem_stall),
        .id_ex_i         (id_ex),
        .mem_result_i    (mem_result),
        .mem_rd_i        (mem_rd),
        .mem_reg_write_i (mem_reg_write),
        .wb_data_i       (wb_data),
        .wb_rd_i         (wb_rd),
        .wb_we_i         (wb_we),
        .ex_mem_o        (ex_mem),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target),
        .ex_rd_o         (ex_rd),
        .ex_mem_read_o   (ex_mem_read)
    );

    memory_writeback u_mem_wb (
        .clk             (clk),
        .reset_i         (reset_i),
        .freeze_i        (mem_stall),
        .ex_mem_i        (ex_mem),
        .dcache_rdata_i  (dcache_rdata_i),
        .dcache_ren_o    (dcache_ren_o),
        .dcache_wen_o    (dcache_wen_o),
        .dcache_addr_o   (dcache_addr_o),
        .dcache_wdata_o  (dcache_wdata_o),
        .mem_result_o    (mem_result),
        .mem_rd_o        (mem_rd),
        .mem_reg_write_o (mem_reg_write),
        .wb_rd_o         (wb_rd),
        .wb_data_o       (wb_data),
        .wb_we_o         (wb_we)
    );

endmodule

/* sim/riscv_pipeline_assertions.sv */
module riscv_pipeline_assertions (
    input logic        clk,
    input logic        reset_i,
    input logic        icache_stall_i,
    input logic        dcache_stall_i,
    input logic [29:0] icache_addr_o,
    input logic        dcache_ren_o,
    input logic        dcache_wen_o,
    input logic [29:0] dcache_addr_o,
    input logic [31:0] dcache_wdata_o,
    input logic [31:0] pc_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // register values of the fixed program under the RV32I rules
    localparam logic [31:0] X1 = 32'd5;
    localparam logic [31:0] X2 = X1 + X1;
    localparam logic [31:0] X3 = X1 - X2;
    localparam logic [31:0] X4 = X3 & X2;
    localparam logic [31:0] X5 = ($signed(X3) < $signed(X4)) ? 32'd1 : 32'd0;
    localparam logic [31:0] X7 = X4 | X5;

    // word addresses of 0x40 and 0x100
    localparam logic [29:0] MID_WADDR = 30'h10;
    localparam logic [29:0] SUM_WADDR = 30'h40;

    localparam logic [31:0] BEQ_TARGET = 32'h2C;
    localparam logic [31:0] JAL_TARGET = 32'h38;
    localparam logic [31:0] JAL_TRAP   = 32'h34;
    localparam logic [31:0] BNE_NEXT   = 32'h30;

    int   fail_count = 0;
    logic bne_seen;

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            bne_seen <= 1'b0;
        end else if (pc_o == BNE_NEXT) begin
            bne_seen <= 1'b1;
        end
    end

    a_reset: assert property (@(posedge clk)
        reset_i |=> (pc_o == '0 && !dcache_ren_o && !dcache_wen_o))
        else begin
            fail_count++;
            $error("reset state wrong: pc or data enables not cleared");
        end

    a_freeze: assert property (@(posedge clk) disable iff (reset_i)
        (icache_stall_i || dcache_stall_i) |=> ($stable(pc_o) && $stable(dcache_ren_o) &&
        $stable(dcache_wen_o) && $stable(dcache_addr_o) && $stable(dcache_wdata_o)))
        else begin
            fail_count++;
            $error("pipeline moved during a cache stall");
        end

    // instruction port carries the word address of the fetch pc
    a_fetch_addr: assert property (@(posedge clk) disable iff (reset_i)
        icache_addr_o == pc_o[31:2])
        else begin
            fail_count++;
            $error("CHECK FAILED fetch_addr expected %h actual %h",
                   pc_o[31:2], icache_addr_o);
        end

    // +4, the taken beq or the jal; hazard hold and the self loop keep pc
    a_pc_step: assert property (@(posedge clk) disable iff (reset_i)
        $changed(pc_o) |-> (pc_o == $past(pc_o) + 32'd4 || pc_o == BEQ_TARGET ||
        pc_o == JAL_TARGET))
        else begin
            fail_count++;
            $error("pc moved to an unexpected address %h", pc_o);
        end

    a_jal_skip: assert property (@(posedge clk) disable iff (reset_i) pc_o != JAL_TRAP)
        else begin
            fail_count++;
            $error("fetch reached the word skipped by jal");
        end

    a_enables: assert property (@(posedge clk) disable iff (reset_i)
        !(dcache_ren_o && dcache_wen_o))
        else begin
            fail_count++;
            $error("data read and write enables high together");
        end

    // trap words store outside this region
    a_store_region: assert property (@(posedge clk) disable iff (reset_i)
        dcache_wen_o |-> (dcache_addr_o == MID_WADDR || dcache_addr_o == SUM_WADDR))
        else begin
            fail_count++;
            $error("store to an address outside the data region");
        end

    a_mid_value: assert property (@(posedge clk) disable iff (reset_i)
        (dcache_wen_o && dcache_addr_o == MID_WADDR) |-> dcache_wdata_o == swap_bytes(X4))
        else begin
            fail_count++;
            $error("CHECK FAILED mid_store expected %h actual %h",
                   swap_bytes(X4), dcache_wdata_o);
        end

    a_sum_value: assert property (@(posedge clk) disable iff (reset_i)
        (dcache_wen_o && dcache_addr_o == SUM_WADDR) |-> dcache_wdata_o == swap_bytes(X7))
        else begin
            fail_count++;
            $error("CHECK FAILED checksum_store expected %h actual %h",
                   swap_bytes(X7), dcache_wdata_o);
        end

    a_bne_path: assert property (@(posedge clk) disable iff (reset_i)
        (dcache_wen_o && dcache_addr_o == SUM_WADDR) |-> bne_seen)
        else begin
            fail_count++;
            $error("checksum stored without passing the not-taken bne");
        end

endmodule

bind riscv_pipeline riscv_pipeline_assertions u_checks (
    .clk            (clk),
    .reset_i        (reset_i),
    .icache_stall_i (icache_stall_i),
    .dcache_stall_i (dcache_stall_i),
    .icache_addr_o  (icache_addr_o),
    .dcache_ren_o   (dcache_ren_o),
    .dcache_wen_o   (dcache_wen_o),
    .dcache_addr_o  (dcache_addr_o),
    .dcache_wdata_o (dcache_wdata_o),
    .pc_o           (pc_o)
);

/* sim/riscv_pipeline_tb.sv */
module riscv_pipeline_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          TIMEOUT_CYCLES = 400;
    localparam logic [29:0] SUM_WADDR      = 30'h40;

    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic        clk;
    logic        reset_i;
    logic [29:0] icache_addr;
    logic [31:0] icache_rdata;
    logic        icache_stall;
    logic        dcache_ren;
    logic        dcache_wen;
    logic [29:0] dcache_addr;
    logic [31:0] dcache_wdata;
    logic [31:0] dcache_rdata;
    logic        dcache_stall;
    logic [31:0] pc;

    logic [31:0] rom [0:15];
    logic [31:0] dmem [0:255];
    logic [1:0]  istall_left;
    logic [1:0]  dstall_left;
    logic        sum_stored;
    int          cycles;
    int          timeout_errors;
    int          assert_errors;

    riscv_pipeline dut_i (
        .clk            (clk),
        .reset_i        (reset_i),
        .icache_addr_o  (icache_addr),
        .icache_rdata_i (icache_rdata),
        .icache_stall_i (icache_stall),
        .dcache_ren_o   (dcache_ren),
        .dcache_wen_o   (dcache_wen),
        .dcache_addr_o  (dcache_addr),
        .dcache_wdata_o (dcache_wdata),
        .dcache_rdata_i (dcache_rdata),
        .dcache_stall_i (dcache_stall),
        .pc_o           (pc)
    );

    function automatic logic [31:0] swap_bytes(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, 3'b010 & {3{opc == OPC_LOAD}}, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    // memories hold the big-endian bus image
    assign icache_rdata = rom[icache_addr[3:0]];
    assign dcache_rdata = dmem[dcache_addr[7:0]];

    always #4 clk = ~clk;

    initial begin
        // trap words store to 0x7c outside the data region
        rom[0]  = enc_i(12'd5, 5'd0, 5'd1, OPC_IMM);
        rom[1]  = enc_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2);
        rom[2]  = enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3);
        rom[3]  = enc_r(7'h00, 5'd2, 5'd3, 3'b111, 5'd4);
        rom[4]  = enc_r(7'h00, 5'd4, 5'd3, 3'b010, 5'd5);
        rom[5]  = enc_s(12'h040, 5'd4, 5'd0);
        rom[6]  = enc_i(12'h040, 5'd0, 5'd6, OPC_LOAD);
        rom[7]  = enc_r(7'h00, 5'd5, 5'd6, 3'b110, 5'd7);
        rom[8]  = enc_b(13'd12, 5'd7, 5'd7, 3'b000);
        rom[9]  = enc_s(12'h07C, 5'd1, 5'd0);
        rom[10] = enc_s(12'h07C, 5'd1, 5'd0);
        rom[11] = enc_b(13'd8, 5'd1, 5'd1, 3'b001);
        rom[12] = enc_j(21'd8, 5'd8);
        rom[13] = enc_s(12'h07C, 5'd1, 5'd0);
        rom[14] = enc_s(12'h100, 5'd7, 5'd0);
        rom[15] = enc_j(21'd0, 5'd0);
        for (int i = 0; i < 16; i++) begin
            rom[i] = swap_bytes(rom[i]);
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] <= {8'hA5, 8'(i), 8'(~i), 8'(i * 3)};
        end
    end

    // random 1 to 3 cycle stall pulses with at least one free cycle between
    always @(posedge clk) begin
        if (reset_i) begin
            icache_stall <= 1'b0;
            dcache_stall <= 1'b0;
            istall_left  <= '0;
            dstall_left  <= '0;
        end else begin
            if (istall_left != 0) begin
                istall_left <= istall_left - 2'd1;
            end else if (icache_stall) begin
                icache_stall <= 1'b0;
            end else if ($urandom_range(0, 5) == 0) begin
                icache_stall <= 1'b1;
                istall_left  <= 2'($urandom_range(0, 2));
            end
            if (dstall_left != 0) begin
                dstall_left <= dstall_left - 2'd1;
            end else if (dcache_stall) begin
                dcache_stall <= 1'b0;
            end else if ($urandom_range(0, 5) == 0) begin
                dcache_stall <= 1'b1;
                dstall_left  <= 2'($urandom_range(0, 2));
            end
        end
    end

    // stores land only in a cycle the pipeline advances
    always @(posedge clk) begin
        if (!reset_i) begin
            cycles <= cycles + 1;
            if (dcache_wen && !icache_stall && !dcache_stall) begin
                dmem[dcache_addr[7:0]] <= dcache_wdata;
                if (dcache_addr == SUM_WADDR) begin
                    sum_stored <= 1'b1;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h1827));
        clk            = 1'b0;
        reset_i        <= 1'b1;
        icache_stall   <= 1'b0;
        dcache_stall   <= 1'b0;
        istall_left    <= '0;
        dstall_left    <= '0;
        sum_stored     <= 1'b0;
        cycles         <= 0;
        timeout_errors = 0;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        while (!sum_stored && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
        end
        if (!sum_stored) begin
            timeout_errors++;
            $display("timeout: checksum store never seen");
        end
        repeat (3) @(posedge clk);
        assert_errors = dut_i.u_checks.fail_count;
        $display("errors: assertions=%0d timeout=%0d cycles=%0d",
                 assert_errors, timeout_errors, cycles);
        if (assert_errors == 0 && timeout_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
common/riscv_pkg.sv
fetch/fetch_stage.sv
decode/register_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
src/memory_writeback.sv
src/riscv_pipeline.sv
sim/riscv_pipeline_assertions.sv
sim/riscv_pipeline_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= riscv_pipeline_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
ERR_LIMIT ?= 1000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG ERR_LIMIT"

test:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
